// ==== logic/mon_config.svh ====
`ifndef MON_CONFIG_SVH
`define MON_CONFIG_SVH

// ram word-address width, 64 words
`define MON_RAM_AW 6

// cycles from read_req to read_valid
`define MON_RD_LAT 2

// host opcode bytes, ascii
// A sets the write address
`define MON_OP_WADR 8'h41
// W writes one word, address counts up
`define MON_OP_WDATA 8'h57
// S sets the dump start address
`define MON_OP_RSTART 8'h53
// E sets the dump end address and starts the dump
`define MON_OP_REND 8'h45
// X stops a running dump
`define MON_OP_RSTOP 8'h58
// T clears the whole ram in the background
`define MON_OP_TRASH 8'h54
// P returns the cpu pc value
`define MON_OP_PC 8'h50

`endif

// ==== logic/mon_cmd_pkg.sv ====
package mon_cmd_pkg;

	// decoded host commands
	// one per opcode byte, CMD_NONE for idle or unknown
	typedef enum logic [2:0] {
		CMD_NONE,
		CMD_WADR,
		CMD_WDATA,
		CMD_RSTART,
		CMD_REND,
		CMD_RSTOP,
		CMD_TRASH,
		CMD_PC
	} cmd_e;

	// decoder states
	// waiting for an opcode byte, or collecting the 4 argument bytes
	typedef enum logic {
		DEC_OPCODE,
		DEC_ARG
	} dec_state_e;

endpackage

// ==== logic/mon_mem_pkg.sv ====
package mon_mem_pkg;

	// ram word, also the width of a host argument
	typedef logic [31:0] word_t;

	// dump fsm states
	// read wait covers the ram read latency
	// send holds the read word until the serializer flushes it
	// pc holds until the pc word is flushed
	typedef enum logic [1:0] {
		DUMP_IDLE,
		DUMP_READ_WAIT,
		DUMP_SEND,
		DUMP_PC
	} dump_state_e;

endpackage

// ==== logic/mon_cmd_decoder.sv ====
`timescale 1ns/1ps
`include "mon_config.svh"

module mon_cmd_decoder (
	input  logic clk,
	input  logic rst_n,
	input  logic [7:0] rx_byte,
	input  logic rx_strobe,
	input  logic flushing_wq,
	output mon_mem_pkg::word_t uart_data,
	output logic write_address_set,
	output logic write_data_en,
	output logic read_start_set,
	output logic read_end_set,
	output logic read_stop,
	output logic start_trash,
	output logic pc_print,
	output logic pc_print_sel
);

	mon_cmd_pkg::dec_state_e dec_state;
	// command decoded from the current rx byte
	mon_cmd_pkg::cmd_e op_cmd;
	// command waiting for its argument
	mon_cmd_pkg::cmd_e cmd_q;
	// command completing in this cycle
	mon_cmd_pkg::cmd_e done_cmd;
	// registered copy, drives the strobes
	mon_cmd_pkg::cmd_e fire_cmd;
	logic [1:0] arg_cnt;

	// opcode byte to command
	always_comb begin
		case (rx_byte)
			`MON_OP_WADR:   op_cmd = mon_cmd_pkg::CMD_WADR;
			`MON_OP_WDATA:  op_cmd = mon_cmd_pkg::CMD_WDATA;
			`MON_OP_RSTART: op_cmd = mon_cmd_pkg::CMD_RSTART;
			`MON_OP_REND:   op_cmd = mon_cmd_pkg::CMD_REND;
			`MON_OP_RSTOP:  op_cmd = mon_cmd_pkg::CMD_RSTOP;
			`MON_OP_TRASH:  op_cmd = mon_cmd_pkg::CMD_TRASH;
			`MON_OP_PC:     op_cmd = mon_cmd_pkg::CMD_PC;
			default:        op_cmd = mon_cmd_pkg::CMD_NONE;
		endcase
	end

	// X and T complete on the opcode byte
	// all others on their fourth argument byte
	always_comb begin
		done_cmd = mon_cmd_pkg::CMD_NONE;
		if (rx_strobe) begin
			if (dec_state == mon_cmd_pkg::DEC_OPCODE) begin
				if (op_cmd == mon_cmd_pkg::CMD_RSTOP || op_cmd == mon_cmd_pkg::CMD_TRASH)
					done_cmd = op_cmd;
			end else if (arg_cnt == 2'd3) begin
				done_cmd = cmd_q;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dec_state <= mon_cmd_pkg::DEC_OPCODE;
			cmd_q <= mon_cmd_pkg::CMD_NONE;
			arg_cnt <= 2'd0;
		end else if (rx_strobe) begin
			if (dec_state == mon_cmd_pkg::DEC_OPCODE) begin
				// unknown opcodes fall through and are dropped
				if (op_cmd != mon_cmd_pkg::CMD_NONE && done_cmd == mon_cmd_pkg::CMD_NONE) begin
					cmd_q <= op_cmd;
					arg_cnt <= 2'd0;
					dec_state <= mon_cmd_pkg::DEC_ARG;
				end
			end else begin
				arg_cnt <= arg_cnt + 2'd1;
				if (arg_cnt == 2'd3)
					dec_state <= mon_cmd_pkg::DEC_OPCODE;
			end
		end
	end

	// argument shifts in msb first, big endian
	always_ff @(posedge clk) begin
		if (rx_strobe && dec_state == mon_cmd_pkg::DEC_ARG)
			uart_data <= {uart_data[23:0], rx_byte};
	end

	// strobes one cycle after the last byte
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			fire_cmd <= mon_cmd_pkg::CMD_NONE;
		else
			fire_cmd <= done_cmd;
	end

	assign write_address_set = (fire_cmd == mon_cmd_pkg::CMD_WADR);
	assign write_data_en = (fire_cmd == mon_cmd_pkg::CMD_WDATA);
	assign read_start_set = (fire_cmd == mon_cmd_pkg::CMD_RSTART);
	assign read_end_set = (fire_cmd == mon_cmd_pkg::CMD_REND);
	assign read_stop = (fire_cmd == mon_cmd_pkg::CMD_RSTOP);
	assign start_trash = (fire_cmd == mon_cmd_pkg::CMD_TRASH);
	assign pc_print = (fire_cmd == mon_cmd_pkg::CMD_PC);

	// pc select rises with pc_print
	// held until the serializer has flushed the pc word
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pc_print_sel <= 1'b0;
		else if (done_cmd == mon_cmd_pkg::CMD_PC)
			pc_print_sel <= 1'b1;
		else if (flushing_wq)
			pc_print_sel <= 1'b0;
	end

endmodule

// ==== logic/mon_mem_access.sv ====
`timescale 1ns/1ps
`include "mon_config.svh"

module mon_mem_access (
	input  logic clk,
	input  logic rst_n,
	input  mon_mem_pkg::word_t uart_data,
	input  logic write_address_set,
	input  logic write_data_en,
	input  logic read_start_set,
	input  logic read_end_set,
	input  logic read_stop,
	input  logic start_trash,
	input  logic pc_print,
	input  logic pc_print_sel,
	input  mon_mem_pkg::word_t pc_data,
	input  logic read_valid,
	input  mon_mem_pkg::word_t read_data,
	input  logic write_finish,
	input  logic flushing_wq,
	output logic read_req,
	output logic [`MON_RAM_AW-1:0] read_adr,
	output logic write_req,
	output logic [`MON_RAM_AW-1:0] write_adr,
	output mon_mem_pkg::word_t write_data,
	output logic rdata_snd_start,
	output mon_mem_pkg::word_t rdata_snd,
	output logic dump_running,
	output logic trash_running
);

	// host write address, counts up per W
	logic [`MON_RAM_AW-1:0] wadr_cntr;
	// a write is out and write_finish not seen yet
	logic write_pend;
	// msb is the running flag, low bits the sweep address
	logic [`MON_RAM_AW:0] trash_cntr;

	// one extra bit so an end of 2^AW reaches the whole ram
	logic [`MON_RAM_AW:0] rd_adr;
	logic [`MON_RAM_AW:0] rd_end;
	logic dump_end;
	mon_mem_pkg::dump_state_e dump_state;
	mon_mem_pkg::dump_state_e dump_state_nx;
	mon_mem_pkg::word_t rdata_hold;
	logic dump_snd;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wadr_cntr <= '0;
		else if (write_address_set)
			wadr_cntr <= uart_data[`MON_RAM_AW-1:0];
		else if (write_data_en)
			wadr_cntr <= wadr_cntr + 1'b1;
	end

	// trash shares the write port with host writes
	// one write per pending window
	assign write_req = (write_data_en | trash_running) & ~write_pend;
	assign write_adr = trash_running ? trash_cntr[`MON_RAM_AW-1:0] : wadr_cntr;
	assign write_data = trash_running ? '0 : uart_data;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			write_pend <= 1'b0;
		else if (write_finish)
			write_pend <= 1'b0;
		else if (write_req)
			write_pend <= 1'b1;
	end

	// sweep steps on each issued write
	// carry out of the last address clears the running bit
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			trash_cntr <= '0;
		else if (start_trash)
			trash_cntr <= {1'b1, {`MON_RAM_AW{1'b0}}};
		else if (trash_running & write_req)
			trash_cntr <= trash_cntr + 1'b1;
	end

	assign trash_running = trash_cntr[`MON_RAM_AW];

	// rd_adr already points past the word in flight
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rd_adr <= '0;
		else if (read_start_set)
			rd_adr <= {1'b0, uart_data[`MON_RAM_AW-1:0]};
		else if (read_req)
			rd_adr <= rd_adr + 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rd_end <= '0;
		else if (read_end_set)
			rd_end <= uart_data[`MON_RAM_AW:0];
	end

	assign dump_end = (rd_adr >= rd_end);
	assign read_adr = rd_adr[`MON_RAM_AW-1:0];

	// read stop wins in every state
	always_comb begin
		dump_state_nx = dump_state;
		case (dump_state)
			mon_mem_pkg::DUMP_IDLE: begin
				if (read_end_set)
					dump_state_nx = mon_mem_pkg::DUMP_READ_WAIT;
				else if (pc_print)
					dump_state_nx = mon_mem_pkg::DUMP_PC;
			end
			mon_mem_pkg::DUMP_READ_WAIT: begin
				if (read_stop)
					dump_state_nx = mon_mem_pkg::DUMP_IDLE;
				else if (read_valid)
					dump_state_nx = mon_mem_pkg::DUMP_SEND;
			end
			mon_mem_pkg::DUMP_SEND: begin
				if (read_stop)
					dump_state_nx = mon_mem_pkg::DUMP_IDLE;
				else if (flushing_wq & dump_end)
					dump_state_nx = mon_mem_pkg::DUMP_IDLE;
				else if (flushing_wq)
					dump_state_nx = mon_mem_pkg::DUMP_READ_WAIT;
			end
			mon_mem_pkg::DUMP_PC: begin
				if (read_stop | flushing_wq)
					dump_state_nx = mon_mem_pkg::DUMP_IDLE;
			end
			default: dump_state_nx = mon_mem_pkg::DUMP_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			dump_state <= mon_mem_pkg::DUMP_IDLE;
		else
			dump_state <= dump_state_nx;
	end

	assign dump_running = (dump_state != mon_mem_pkg::DUMP_IDLE);

	// read request pulses on entry to read wait
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			read_req <= 1'b0;
		else
			read_req <= (dump_state_nx == mon_mem_pkg::DUMP_READ_WAIT) &&
				(dump_state != mon_mem_pkg::DUMP_READ_WAIT);
	end

	// a late read after stop is dropped
	always_ff @(posedge clk) begin
		if (read_valid && dump_state == mon_mem_pkg::DUMP_READ_WAIT)
			rdata_hold <= read_data;
	end

	// send pulse on entry to DUMP_SEND, one cycle after read_valid
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			dump_snd <= 1'b0;
		else
			dump_snd <= (dump_state_nx == mon_mem_pkg::DUMP_SEND) &&
				(dump_state != mon_mem_pkg::DUMP_SEND);
	end

	// pc word goes out in the pc_print cycle itself
	assign rdata_snd_start = dump_snd | pc_print;
	assign rdata_snd = pc_print_sel ? pc_data : rdata_hold;

	a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(read_req && write_req))
		else $error("read_req and write_req together");

	// a host write must find the write port free, or it is lost
	a_wr_one_out: assert property (@(posedge clk) disable iff (!rst_n)
		write_data_en |-> (!write_pend && !trash_running))
		else $error("host write while the write port is busy");

endmodule

// ==== logic/mon_tx_serializer.sv ====
`timescale 1ns/1ps

module mon_tx_serializer (
	input  logic clk,
	input  logic rst_n,
	input  logic rdata_snd_start,
	input  mon_mem_pkg::word_t rdata_snd,
	input  logic tx_ready,
	output logic [7:0] tx_byte,
	output logic tx_valid,
	output logic flushing_wq
);

	// shifts left one byte per transfer
	mon_mem_pkg::word_t word_q;
	// bytes already sent of this word
	logic [1:0] byte_cnt;
	logic xfer;

	assign xfer = tx_valid & tx_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_valid <= 1'b0;
			byte_cnt <= 2'd0;
		end else if (rdata_snd_start) begin
			tx_valid <= 1'b1;
			byte_cnt <= 2'd0;
		end else if (xfer) begin
			byte_cnt <= byte_cnt + 2'd1;
			// last byte gone
			if (byte_cnt == 2'd3)
				tx_valid <= 1'b0;
		end
	end

	// payload only
	always_ff @(posedge clk) begin
		if (rdata_snd_start)
			word_q <= rdata_snd;
		else if (xfer)
			word_q <= {word_q[23:0], 8'h00};
	end

	// msb first
	assign tx_byte = word_q[31:24];

	// word done with the fourth transfer
	assign flushing_wq = xfer & (byte_cnt == 2'd3);

	a_tx_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_byte)))
		else $error("tx_byte changed under back-pressure");

endmodule

// ==== logic/mon_ram.sv ====
`timescale 1ns/1ps
`include "mon_config.svh"

module mon_ram (
	input  logic clk,
	input  logic rst_n,
	input  logic read_req,
	input  logic [`MON_RAM_AW-1:0] read_adr,
	input  logic write_req,
	input  logic [`MON_RAM_AW-1:0] write_adr,
	input  mon_mem_pkg::word_t write_data,
	output logic read_valid,
	output mon_mem_pkg::word_t read_data,
	output logic write_finish
);

	mon_mem_pkg::word_t mem [2**`MON_RAM_AW];
	// read pipeline, stage 0 holds the array output
	logic [`MON_RD_LAT-1:0] vld_pipe;
	mon_mem_pkg::word_t data_pipe [`MON_RD_LAT];

	always_ff @(posedge clk) begin
		if (write_req)
			mem[write_adr] <= write_data;
	end

	// write takes one cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			write_finish <= 1'b0;
		else
			write_finish <= write_req;
	end

	// several reads may be in flight
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vld_pipe <= '0;
		end else begin
			vld_pipe[0] <= read_req;
			for (int i = 1; i < `MON_RD_LAT; i++)
				vld_pipe[i] <= vld_pipe[i-1];
		end
	end

	always_ff @(posedge clk) begin
		data_pipe[0] <= mem[read_adr];
		for (int i = 1; i < `MON_RD_LAT; i++)
			data_pipe[i] <= data_pipe[i-1];
	end

	assign read_valid = vld_pipe[`MON_RD_LAT-1];
	assign read_data = data_pipe[`MON_RD_LAT-1];

endmodule

// ==== logic/uart_monitor_top.sv ====
`timescale 1ns/1ps
`include "mon_config.svh"

module uart_monitor_top (
	input  logic clk,
	input  logic rst_n,
	input  logic [7:0] rx_byte,
	input  logic rx_strobe,
	output logic [7:0] tx_byte,
	output logic tx_valid,
	input  logic tx_ready,
	input  mon_mem_pkg::word_t pc_data,
	output logic dump_running,
	output logic trash_running
);

	// decoder to memory access
	mon_mem_pkg::word_t uart_data;
	logic write_address_set;
	logic write_data_en;
	logic read_start_set;
	logic read_end_set;
	logic read_stop;
	logic start_trash;
	logic pc_print;
	logic pc_print_sel;

	// memory access to ram
	logic read_req;
	logic [`MON_RAM_AW-1:0] read_adr;
	logic read_valid;
	mon_mem_pkg::word_t read_data;
	logic write_req;
	logic [`MON_RAM_AW-1:0] write_adr;
	mon_mem_pkg::word_t write_data;
	logic write_finish;

	// memory access to serializer
	logic rdata_snd_start;
	mon_mem_pkg::word_t rdata_snd;
	logic flushing_wq;

	mon_cmd_decoder i_decoder (.*);

	mon_mem_access i_mem_access (.*);

	mon_ram i_ram (.*);

	mon_tx_serializer i_serializer (.*);

endmodule

// ==== test/tb_uart_monitor.sv ====
`timescale 1ns/1ps
`include "mon_config.svh"

module tb_uart_monitor;

	logic clk;
	logic rst_n;
	logic [7:0] rx_byte;
	logic rx_strobe;
	logic [7:0] tx_byte;
	logic tx_valid;
	logic tx_ready;
	mon_mem_pkg::word_t pc_data;
	logic dump_running;
	logic trash_running;

	// case file contents, one entry per line
	logic [7:0] tags[$];
	mon_mem_pkg::word_t args[$];
	int trash_cnt = 0;
	int err_cnt = 0;
	int cycle_cnt = 0;
	int cycle_limit = 0;
	// forces tx_ready low while set
	logic hold_ready = 1'b0;

	// response collector state
	mon_mem_pkg::word_t resp_q[$];
	mon_mem_pkg::word_t shift_word;
	int part_cnt = 0;

	uart_monitor_top i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.rx_byte(rx_byte),
		.rx_strobe(rx_strobe),
		.tx_byte(tx_byte),
		.tx_valid(tx_valid),
		.tx_ready(tx_ready),
		.pc_data(pc_data),
		.dump_running(dump_running),
		.trash_running(trash_running)
	);

	always #2 clk = ~clk;

	// random back-pressure on the byte output
	always @(posedge clk) begin
		if (hold_ready)
			tx_ready <= 1'b0;
		else
			tx_ready <= ($urandom % 4) != 0;
	end

	// bytes arrive msb first, four per word
	always @(posedge clk) begin
		if (rst_n && tx_valid && tx_ready) begin
			shift_word = {shift_word[23:0], tx_byte};
			part_cnt++;
			if (part_cnt == 4) begin
				resp_q.push_back(shift_word);
				part_cnt = 0;
			end
		end
	end

	// watchdog
	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > cycle_limit) begin
			$display("Timeout: the run hung, no progress after %0d cycles", cycle_cnt);
			end_in_failure();
		end
	end

	task automatic end_in_failure();
		$display("=== FAIL ===");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(input string name, input mon_mem_pkg::word_t exp,
		input mon_mem_pkg::word_t act);
		if (act !== exp) begin
			err_cnt++;
			$display("Fail at %0t: %s expected %08h got %08h", $time, name, exp, act);
			end_in_failure();
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			err_cnt++;
			$display("Fail at %0t: %s expected %b got %b", $time, name, exp, act);
			end_in_failure();
		end
	endtask

	// '#' starts a comment, otherwise tag letter then hex argument
	task automatic load_cases();
		int fd;
		int c;
		int n;
		logic [7:0] tag;
		mon_mem_pkg::word_t arg;
		fd = $fopen("test/monitor_cases.txt", "r");
		if (fd == 0) begin
			$display("Error: cannot open the case file test/monitor_cases.txt");
			end_in_failure();
		end else begin
			c = $fgetc(fd);
			while (c != -1) begin
				if (c == "#") begin
					while (c != -1 && c != "\n")
						c = $fgetc(fd);
				end else if (c != " " && c != "\n" && c != "\r" && c != "\t") begin
					tag = c[7:0];
					n = $fscanf(fd, "%h", arg);
					if (n != 1) begin
						$display("Error: case line with tag %c has no hex argument", tag);
						end_in_failure();
					end else begin
						tags.push_back(tag);
						args.push_back(arg);
						if (tag == "T")
							trash_cnt++;
					end
				end
				c = $fgetc(fd);
			end
			$fclose(fd);
		end
	endtask

	function automatic mon_cmd_pkg::cmd_e cmd_of_tag(input logic [7:0] tag);
		case (tag)
			"A": return mon_cmd_pkg::CMD_WADR;
			"W": return mon_cmd_pkg::CMD_WDATA;
			"S": return mon_cmd_pkg::CMD_RSTART;
			"E": return mon_cmd_pkg::CMD_REND;
			"X": return mon_cmd_pkg::CMD_RSTOP;
			"T": return mon_cmd_pkg::CMD_TRASH;
			"P": return mon_cmd_pkg::CMD_PC;
			default: return mon_cmd_pkg::CMD_NONE;
		endcase
	endfunction

	// one to three idle cycles before each byte
	task automatic send_byte(input logic [7:0] b);
		int gap;
		gap = 1 + ($urandom % 3);
		repeat (gap) @(posedge clk);
		rx_byte <= b;
		rx_strobe <= 1'b1;
		@(posedge clk);
		rx_strobe <= 1'b0;
	endtask

	task automatic send_cmd(input mon_cmd_pkg::cmd_e cmd, input mon_mem_pkg::word_t arg);
		logic [7:0] op;
		case (cmd)
			mon_cmd_pkg::CMD_WADR:   op = `MON_OP_WADR;
			mon_cmd_pkg::CMD_WDATA:  op = `MON_OP_WDATA;
			mon_cmd_pkg::CMD_RSTART: op = `MON_OP_RSTART;
			mon_cmd_pkg::CMD_REND:   op = `MON_OP_REND;
			mon_cmd_pkg::CMD_RSTOP:  op = `MON_OP_RSTOP;
			mon_cmd_pkg::CMD_TRASH:  op = `MON_OP_TRASH;
			default:                 op = `MON_OP_PC;
		endcase
		send_byte(op);
		// stop and trash carry no argument
		if (cmd != mon_cmd_pkg::CMD_RSTOP && cmd != mon_cmd_pkg::CMD_TRASH) begin
			for (int i = 3; i >= 0; i--)
				send_byte(arg[8*i +: 8]);
		end
	endtask

	// queue is read at falling edges, away from the collector
	task automatic expect_word(input mon_mem_pkg::word_t exp);
		mon_mem_pkg::word_t got;
		@(negedge clk);
		while (resp_q.size() == 0)
			@(negedge clk);
		got = resp_q.pop_front();
		check_word("response word", exp, got);
	endtask

	task automatic expect_silence(input int cycles);
		repeat (cycles) @(negedge clk);
		if (resp_q.size() != 0 || part_cnt != 0) begin
			$display("Error: the DUT sent response bytes that no case expects");
			end_in_failure();
		end else begin
			check_flag("tx_valid", 1'b0, tx_valid);
		end
	endtask

	task automatic run_case(input logic [7:0] tag, input mon_mem_pkg::word_t arg);
		if (cmd_of_tag(tag) != mon_cmd_pkg::CMD_NONE) begin
			send_cmd(cmd_of_tag(tag), arg);
		end else begin
			case (tag)
				"R": expect_word(arg);
				"C": begin
					@(posedge clk);
					pc_data <= arg;
				end
				"H": begin
					@(negedge clk);
					hold_ready = arg[0];
				end
				"V": begin
					@(negedge clk);
					while (!tx_valid)
						@(negedge clk);
				end
				"D": begin
					@(negedge clk);
					while (dump_running || trash_running)
						@(negedge clk);
				end
				// flags settle within a few cycles of the last byte
				"F": begin
					repeat (4) @(negedge clk);
					check_flag("dump_running", arg[4], dump_running);
					check_flag("trash_running", arg[0], trash_running);
				end
				"N": expect_silence(arg);
				default: begin
					$display("Error: unknown tag %c in the case file", tag);
					end_in_failure();
				end
			endcase
		end
	endtask

	initial begin
		void'($urandom(32'ha632_d945));
		clk = 1'b0;
		rst_n = 1'b0;
		rx_byte = 8'h00;
		rx_strobe = 1'b0;
		tx_ready = 1'b0;
		pc_data = '0;
		load_cases();
		// reset, per-line budget, and a full sweep per trash
		cycle_limit = 20 + 200 * tags.size() + 4 * (2 ** `MON_RAM_AW) * trash_cnt;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk);
		for (int i = 0; i < tags.size(); i++)
			run_case(tags[i], args[i]);
		if (err_cnt == 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			end_in_failure();
		end
	end

endmodule

// ==== test/monitor_cases.txt ====
# tag and hex argument, one per line
# A W S E X T P send a command, R expects a word, C sets pc_data, H 1 holds tx_ready low
# V waits for tx_valid, D waits for idle, F checks dump (bit 4) and trash (bit 0), N expects silence
# three words from address 10, dumped back
A 00000010
W 11110000
W 22220001
W 33330002
S 00000010
E 00000013
R 11110000
R 22220001
R 33330002
D 0
# end equal to start gives one word
S 00000011
E 00000011
R 22220001
D 0
# trash, then zeros come back
T 0
F 01
D 0
F 00
S 00000010
E 00000012
R 00000000
R 00000000
D 0
# pc readback
C 1234abcd
P 0
R 1234abcd
F 00
# stop a long dump while the first word is held
A 00000020
W cafe0020
H 1
S 00000020
E 00000040
V 0
X 0
F 00
H 0
R cafe0020
N 40

// ==== uart_monitor.f ====
+incdir+logic
logic/mon_cmd_pkg.sv
logic/mon_mem_pkg.sv
logic/mon_cmd_decoder.sv
logic/mon_mem_access.sv
logic/mon_tx_serializer.sv
logic/mon_ram.sv
logic/uart_monitor_top.sv
test/tb_uart_monitor.sv
